/* files.f */
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/wb_bus_master.sv
hdl/instr_sequencer.sv
hdl/cpu_top.sv
testbench/wb_memory.sv
testbench/tb_cpu.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t i_op,
    input  cpu_pkg::word_t   i_a,
    input  cpu_pkg::word_t   i_b,
    input  logic             i_word,
    input  cpu_pkg::flags_t  i_flags,
    output cpu_pkg::word_t   o_res,
    output cpu_pkg::flags_t  o_flags
);
    import cpu_pkg::*;

    word_t       a_m;
    word_t       b_m;
    logic [16:0] sum;   // Bit 16 or 8 is the carry out
    logic        cin;
    logic        a_top;
    logic        b_top;
    logic        r_top;

    always_comb begin
        // Byte form uses only the low halves
        a_m = i_word ? i_a : {8'h00, i_a[7:0]};
        b_m = i_word ? i_b : {8'h00, i_b[7:0]};
        cin = i_flags[FLAG_CF];

        case (i_op)
            ALU_ADD: sum = {1'b0, a_m} + {1'b0, b_m};
            ALU_ADC: sum = {1'b0, a_m} + {1'b0, b_m} + {16'h0000, cin};
            ALU_SBB: sum = {1'b0, a_m} - {1'b0, b_m} - {16'h0000, cin};
            ALU_SUB,
            ALU_CMP: sum = {1'b0, a_m} - {1'b0, b_m};
            ALU_AND: sum = {1'b0, a_m & b_m};
            ALU_OR:  sum = {1'b0, a_m | b_m};
            ALU_XOR: sum = {1'b0, a_m ^ b_m};
            default: sum = '0;
        endcase

        a_top = i_word ? a_m[15] : a_m[7];
        b_top = i_word ? b_m[15] : b_m[7];
        r_top = i_word ? sum[15] : sum[7];
        o_res = i_word ? sum[15:0] : {8'h00, sum[7:0]};

        // ----------------------------------------
        // Flags
        // ----------------------------------------
        o_flags          = i_flags;
        o_flags[FLAG_CF] = i_word ? sum[16] : sum[8];
        o_flags[FLAG_AF] = a_m[4] ^ b_m[4] ^ sum[4];

        case (i_op)
            ALU_ADD,
            ALU_ADC: o_flags[FLAG_OF] = ~(a_top ^ b_top) & (a_top ^ r_top);
            ALU_SBB,
            ALU_SUB,
            ALU_CMP: o_flags[FLAG_OF] = (a_top ^ b_top) & (a_top ^ r_top);
            default: begin  // Logical group
                o_flags[FLAG_OF] = 1'b0;
                o_flags[FLAG_CF] = 1'b0;
                o_flags[FLAG_AF] = 1'b0;
            end
        endcase

        o_flags[FLAG_SF] = r_top;
        o_flags[FLAG_ZF] = (o_res == 16'h0000);
        o_flags[FLAG_PF] = ~^sum[7:0];  // Even parity of low byte
    end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------
    typedef logic [15:0] word_t;    // Data word or byte address
    typedef logic [7:0]  byte_t;    // One bus transfer
    typedef logic [11:0] flags_t;   // 8086 flags layout
    typedef logic [2:0]  reg_idx_t; // Register number from the opcode

    // ALU operations in opcode bits [5:3] order
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_OR,
        ALU_ADC,
        ALU_SBB,
        ALU_AND,
        ALU_SUB,
        ALU_XOR,
        ALU_CMP
    } alu_op_t;

    // Sequencer states
    typedef enum logic [2:0] {
        FETCH,      // Opcode byte at IP
        IMM_LO,     // Immediate or rel8 byte
        IMM_HI,     // High immediate byte of word forms
        EXEC,       // Register and flag write-back
        XCHG2,      // Second half of XCHG
        PUSH_LO,    // Low byte store at SP-2
        PUSH_HI     // High byte store at SP-1
    } seq_state_t;

    // ----------------------------------------
    // Flag bit positions
    // ----------------------------------------
    localparam int FLAG_CF = 0;
    localparam int FLAG_PF = 2;
    localparam int FLAG_AF = 4;
    localparam int FLAG_ZF = 6;
    localparam int FLAG_SF = 7;
    localparam int FLAG_IF = 9;
    localparam int FLAG_DF = 10;
    localparam int FLAG_OF = 11;

    // Word register numbers
    localparam reg_idx_t REG_AX = 3'd0;
    localparam reg_idx_t REG_CX = 3'd1;
    localparam reg_idx_t REG_DX = 3'd2;
    localparam reg_idx_t REG_BX = 3'd3;
    localparam reg_idx_t REG_SP = 3'd4;
    localparam reg_idx_t REG_BP = 3'd5;
    localparam reg_idx_t REG_SI = 3'd6;
    localparam reg_idx_t REG_DI = 3'd7;

    // Start-up values
    localparam word_t RESET_IP = 16'h0000;
    localparam word_t RESET_SP = 16'hFFFE;

endpackage

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic           clock,
    input  logic           i_rst_n,
    output logic           o_wb_cyc,
    output logic           o_wb_stb,
    output logic           o_wb_we,
    output cpu_pkg::word_t o_wb_adr,
    output cpu_pkg::byte_t o_wb_dat,
    input  cpu_pkg::byte_t i_wb_dat,
    input  logic           i_wb_ack
);
    import cpu_pkg::*;

    // Sequencer to bus master
    logic     bus_req;
    logic     bus_we;
    word_t    bus_adr;
    byte_t    bus_wdat;
    logic     bus_done;
    byte_t    bus_rdat;

    // Register file
    word_t    regs [8];
    flags_t   flags;
    logic     reg_we;
    reg_idx_t reg_idx;
    logic     reg_word;
    word_t    reg_wdat;
    logic     flags_we;
    flags_t   flags_wdat;

    // ALU
    alu_op_t  alu_op;
    word_t    alu_a;
    word_t    alu_b;
    logic     alu_word;
    word_t    alu_res;
    flags_t   alu_flags;

    wb_bus_master u_bus (
        .clock    (clock),
        .i_rst_n  (i_rst_n),
        .i_req    (bus_req),
        .i_we     (bus_we),
        .i_adr    (bus_adr),
        .i_wdat   (bus_wdat),
        .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack),
        .o_done   (bus_done),
        .o_rdat   (bus_rdat),
        .o_wb_cyc (o_wb_cyc),
        .o_wb_stb (o_wb_stb),
        .o_wb_we  (o_wb_we),
        .o_wb_adr (o_wb_adr),
        .o_wb_dat (o_wb_dat)
    );

    instr_sequencer u_seq (
        .clock        (clock),
        .i_rst_n      (i_rst_n),
        .i_done       (bus_done),
        .i_rdat       (bus_rdat),
        .i_regs       (regs),
        .i_flags      (flags),
        .i_alu_res    (alu_res),
        .i_alu_flags  (alu_flags),
        .o_req        (bus_req),
        .o_we         (bus_we),
        .o_adr        (bus_adr),
        .o_wdat       (bus_wdat),
        .o_reg_we     (reg_we),
        .o_reg_idx    (reg_idx),
        .o_reg_word   (reg_word),
        .o_reg_wdat   (reg_wdat),
        .o_flags_we   (flags_we),
        .o_flags_wdat (flags_wdat),
        .o_alu_op     (alu_op),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .o_alu_word   (alu_word)
    );

    alu u_alu (
        .i_op    (alu_op),
        .i_a     (alu_a),
        .i_b     (alu_b),
        .i_word  (alu_word),
        .i_flags (flags),
        .o_res   (alu_res),
        .o_flags (alu_flags)
    );

    register_file u_regs (
        .clock        (clock),
        .i_rst_n      (i_rst_n),
        .i_we         (reg_we),
        .i_idx        (reg_idx),
        .i_word       (reg_word),
        .i_wdat       (reg_wdat),
        .i_flags_we   (flags_we),
        .i_flags_wdat (flags_wdat),
        .o_regs       (regs),
        .o_flags      (flags)
    );

endmodule

/* hdl/instr_sequencer.sv */
`timescale 1ns/1ps

module instr_sequencer (
    input  logic                clock,
    input  logic                i_rst_n,
    input  logic                i_done,
    input  cpu_pkg::byte_t      i_rdat,
    input  cpu_pkg::word_t      i_regs [8],
    input  cpu_pkg::flags_t     i_flags,
    input  cpu_pkg::word_t      i_alu_res,
    input  cpu_pkg::flags_t     i_alu_flags,
    output logic                o_req,
    output logic                o_we,
    output cpu_pkg::word_t      o_adr,
    output cpu_pkg::byte_t      o_wdat,
    output logic                o_reg_we,
    output cpu_pkg::reg_idx_t   o_reg_idx,
    output logic                o_reg_word,
    output cpu_pkg::word_t      o_reg_wdat,
    output logic                o_flags_we,
    output cpu_pkg::flags_t     o_flags_wdat,
    output cpu_pkg::alu_op_t    o_alu_op,
    output cpu_pkg::word_t      o_alu_a,
    output cpu_pkg::word_t      o_alu_b,
    output logic                o_alu_word
);
    import cpu_pkg::*;

    seq_state_t state;
    word_t      ip;
    byte_t      opcode;
    word_t      imm;        // Immediate or rel8
    word_t      hold;       // PUSH data or old AX for XCHG
    word_t      sp_dec;
    word_t      rel8;
    logic [7:0] cond;
    logic       jump_taken;

    // Instruction classes of the latched opcode
    logic is_alu;
    logic is_mov;
    logic is_jcc;
    logic is_incdec;
    logic is_xchg;
    logic is_flag;
    logic imm_word;

    assign is_alu    = (opcode[7:6] == 2'b00) && (opcode[2:1] == 2'b10);
    assign is_mov    = (opcode[7:4] == 4'b1011);
    assign is_jcc    = (opcode[7:4] == 4'b0111);
    assign is_incdec = (opcode[7:4] == 4'b0100);
    assign is_xchg   = (opcode[7:3] == 5'b10010);
    assign is_flag   = (opcode[7:3] == 5'b11111) && (opcode[2:1] != 2'b11);
    assign imm_word  = (is_alu && opcode[0]) || (is_mov && opcode[3]);

    assign sp_dec = i_regs[REG_SP] - 16'd2;
    assign rel8   = {{8{imm[7]}}, imm[7:0]};

    // Jcc conditions indexed by opcode[3:1]
    assign cond = {
        (i_flags[FLAG_SF] ^ i_flags[FLAG_OF]) | i_flags[FLAG_ZF],   // LE
        i_flags[FLAG_SF] ^ i_flags[FLAG_OF],                        // L
        i_flags[FLAG_PF],
        i_flags[FLAG_SF],
        i_flags[FLAG_CF] | i_flags[FLAG_ZF],                        // BE
        i_flags[FLAG_ZF],
        i_flags[FLAG_CF],
        i_flags[FLAG_OF]
    };
    assign jump_taken = cond[opcode[3:1]] ^ opcode[0];

    // ----------------------------------------
    // State and IP
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state <= FETCH;
            ip    <= RESET_IP;
        end else begin
            case (state)
                FETCH: begin
                    if (i_done) begin
                        ip <= ip + 16'd1;
                        casez (i_rdat)
                            8'b00???10?,
                            8'b1011????,
                            8'b0111????: state <= IMM_LO;
                            8'b0100????,
                            8'b10010???,
                            8'b1111100?,
                            8'b1111101?,
                            8'b1111110?: state <= EXEC;
                            8'b01010???: state <= PUSH_LO;
                            default:     state <= FETCH;   // Unknown opcode
                        endcase
                    end
                end
                IMM_LO: begin
                    if (i_done) begin
                        ip    <= ip + 16'd1;
                        state <= imm_word ? IMM_HI : EXEC;
                    end
                end
                IMM_HI: begin
                    if (i_done) begin
                        ip    <= ip + 16'd1;
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (is_jcc && jump_taken)
                        ip <= ip + rel8;    // IP already past rel8
                    state <= is_xchg ? XCHG2 : FETCH;
                end
                XCHG2:   state <= FETCH;
                PUSH_LO: if (i_done) state <= PUSH_HI;
                PUSH_HI: if (i_done) state <= FETCH;
                default: state <= FETCH;
            endcase
        end
    end

    // Opcode and operand latches
    always_ff @(posedge clock) begin
        if (state == FETCH && i_done) begin
            opcode <= i_rdat;
            hold   <= (i_rdat[7:3] == 5'b10010) ? i_regs[REG_AX] : i_regs[i_rdat[2:0]];
        end
        if (state == IMM_LO && i_done)
            imm[7:0] <= i_rdat;
        if (state == IMM_HI && i_done)
            imm[15:8] <= i_rdat;
    end

    // ----------------------------------------
    // Bus requests
    // ----------------------------------------
    always_comb begin
        o_req  = 1'b0;
        o_we   = 1'b0;
        o_adr  = ip;
        o_wdat = hold[7:0];
        case (state)
            FETCH, IMM_LO, IMM_HI: o_req = 1'b1;
            PUSH_LO: begin
                o_req = 1'b1;
                o_we  = 1'b1;
                o_adr = sp_dec;
            end
            PUSH_HI: begin
                o_req  = 1'b1;
                o_we   = 1'b1;
                o_adr  = sp_dec + 16'd1;
                o_wdat = hold[15:8];
            end
            default: o_req = 1'b0;
        endcase
    end

    // ALU operands for INC/DEC or the accumulator with immediate
    assign o_alu_op   = is_incdec ? (opcode[3] ? ALU_SUB : ALU_ADD) : alu_op_t'(opcode[5:3]);
    assign o_alu_a    = is_incdec ? i_regs[opcode[2:0]] : i_regs[REG_AX];
    assign o_alu_b    = is_incdec ? 16'd1 : imm;
    assign o_alu_word = is_incdec || opcode[0];

    // ----------------------------------------
    // Register and flag write-back
    // ----------------------------------------
    always_comb begin
        o_reg_we     = 1'b0;
        o_reg_idx    = opcode[2:0];
        o_reg_word   = 1'b1;
        o_reg_wdat   = imm;
        o_flags_we   = 1'b0;
        o_flags_wdat = i_alu_flags;
        case (state)
            EXEC: begin
                if (is_alu) begin
                    o_reg_we   = (opcode[5:3] != ALU_CMP);
                    o_reg_idx  = REG_AX;    // AL in byte form
                    o_reg_word = opcode[0];
                    o_reg_wdat = i_alu_res;
                    o_flags_we = 1'b1;
                end else if (is_mov) begin
                    o_reg_we   = 1'b1;
                    o_reg_word = opcode[3];
                end else if (is_incdec) begin
                    o_reg_we   = 1'b1;
                    o_reg_wdat = i_alu_res;
                    o_flags_we = 1'b1;
                    o_flags_wdat[FLAG_CF] = i_flags[FLAG_CF];
                end else if (is_xchg) begin
                    o_reg_we   = 1'b1;
                    o_reg_idx  = REG_AX;
                    o_reg_wdat = i_regs[opcode[2:0]];
                end else if (is_flag) begin
                    o_flags_we   = 1'b1;
                    o_flags_wdat = i_flags;
                    case (opcode[2:1])
                        2'b00:   o_flags_wdat[FLAG_CF] = opcode[0];
                        2'b01:   o_flags_wdat[FLAG_IF] = opcode[0];
                        default: o_flags_wdat[FLAG_DF] = opcode[0];
                    endcase
                end
            end
            XCHG2: begin
                o_reg_we   = 1'b1;
                o_reg_wdat = hold;  // Old AX
            end
            PUSH_HI: begin
                o_reg_we   = i_done;
                o_reg_idx  = REG_SP;
                o_reg_wdat = sp_dec;
            end
            default: o_reg_we = 1'b0;
        endcase
    end

    // A pending request keeps its address, direction and store data until done
    a_req_held: assert property (@(posedge clock) disable iff (!i_rst_n)
        (o_req && !i_done) |=>
            (o_req && $stable(o_adr) && $stable(o_we) && (!o_we || $stable(o_wdat))));

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic              clock,
    input  logic              i_rst_n,
    input  logic              i_we,
    input  cpu_pkg::reg_idx_t i_idx,
    input  logic              i_word,
    input  cpu_pkg::word_t    i_wdat,
    input  logic              i_flags_we,
    input  cpu_pkg::flags_t   i_flags_wdat,
    output cpu_pkg::word_t    o_regs [8],
    output cpu_pkg::flags_t   o_flags
);
    import cpu_pkg::*;

    reg_idx_t byte_reg;

    // AL..BL and AH..BH share AX..BX
    assign byte_reg = {1'b0, i_idx[1:0]};

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 8; i++)
                o_regs[i] <= (i == int'(REG_SP)) ? RESET_SP : 16'h0000;
            o_flags <= '0;
        end else begin
            if (i_we) begin
                if (i_word)
                    o_regs[i_idx] <= i_wdat;
                else if (i_idx[2])
                    o_regs[byte_reg][15:8] <= i_wdat[7:0];  // High half
                else
                    o_regs[byte_reg][7:0] <= i_wdat[7:0];
            end
            if (i_flags_we)
                o_flags <= i_flags_wdat;
        end
    end

    // Byte writes need a known register number
    a_byte_idx_known: assert property (@(posedge clock) disable iff (!i_rst_n)
        (i_we && !i_word) |-> !$isunknown(i_idx));

endmodule

/* hdl/wb_bus_master.sv */
`timescale 1ns/1ps

module wb_bus_master (
    input  logic           clock,
    input  logic           i_rst_n,
    input  logic           i_req,
    input  logic           i_we,
    input  cpu_pkg::word_t i_adr,
    input  cpu_pkg::byte_t i_wdat,
    input  cpu_pkg::byte_t i_wb_dat,
    input  logic           i_wb_ack,
    output logic           o_done,
    output cpu_pkg::byte_t o_rdat,
    output logic           o_wb_cyc,
    output logic           o_wb_stb,
    output logic           o_wb_we,
    output cpu_pkg::word_t o_wb_adr,
    output cpu_pkg::byte_t o_wb_dat
);
    import cpu_pkg::*;

    typedef enum logic {
        BUS_IDLE,
        BUS_ACTIVE
    } bus_state_t;

    bus_state_t state;
    logic       start;

    // The requester still holds i_req in its o_done cycle
    assign start = (state == BUS_IDLE) && i_req && !o_done;

    // ----------------------------------------
    // Cycle control
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state    <= BUS_IDLE;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_we  <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (start) begin
                state    <= BUS_ACTIVE;
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                o_wb_we  <= i_we;
            end else if (state == BUS_ACTIVE && i_wb_ack) begin
                state    <= BUS_IDLE;   // Cycle ends on this edge
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_we  <= 1'b0;
                o_done   <= 1'b1;
            end
        end
    end

    // Address, write data and read capture
    always_ff @(posedge clock) begin
        if (start) begin
            o_wb_adr <= i_adr;
            o_wb_dat <= i_wdat;
        end
        if (state == BUS_ACTIVE && i_wb_ack && !o_wb_we)
            o_rdat <= i_wb_dat;
    end

    a_stb_in_cyc: assert property (@(posedge clock) disable iff (!i_rst_n)
        o_wb_stb |-> o_wb_cyc);

    // Pending cycle keeps its address and direction until ack
    a_stable_pending: assert property (@(posedge clock) disable iff (!i_rst_n)
        (o_wb_stb && !i_wb_ack) |=> ($stable(o_wb_adr) && $stable(o_wb_we)));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cpu -f files.f -o sim_tb_cpu

./obj_dir/sim_tb_cpu | tee sim.log

if grep -qx '\*\* PASS \*\*' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    typedef struct packed {
        alu_op_t     op;
        logic        w;         // Word form
        logic [15:0] a;         // MOV value
        logic [15:0] b;         // ALU immediate
        logic [7:0]  jcc;       // Conditional jump opcode
    } row_t;

    localparam int NUM_ROWS       = 18;
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + 2) * 20 * 5;

    logic        clock;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    word_t       wb_adr;
    byte_t       wb_dat_w;
    byte_t       wb_dat_r;
    logic        wb_ack;

    row_t        table_rows [NUM_ROWS];
    int          errors;
    int          cycles;
    int          end_seen;
    logic [15:0] pc;
    logic [15:0] end_addr;

    // Reference model state
    logic [15:0] m_ax;
    logic [15:0] m_cx;
    logic [15:0] m_dx;
    logic [15:0] m_sp;
    logic        m_cf;
    logic        m_pf;
    logic        m_zf;
    logic        m_sf;
    logic        m_of;
    logic [15:0] exp_adr [256];
    logic [7:0]  exp_dat [256];
    int          exp_n;

    cpu_top dut0 (
        .clock    (clock),
        .i_rst_n  (rst_n),
        .o_wb_cyc (wb_cyc),
        .o_wb_stb (wb_stb),
        .o_wb_we  (wb_we),
        .o_wb_adr (wb_adr),
        .o_wb_dat (wb_dat_w),
        .i_wb_dat (wb_dat_r),
        .i_wb_ack (wb_ack)
    );

    wb_memory wb_mem0 (
        .clock (clock),
        .i_cyc (wb_cyc),
        .i_stb (wb_stb),
        .i_we  (wb_we),
        .i_adr (wb_adr),
        .i_dat (wb_dat_w),
        .o_dat (wb_dat_r),
        .o_ack (wb_ack)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Cycle count and final jump fetches
    always @(posedge clock) begin
        cycles++;
        if (wb_cyc && wb_stb && !wb_we && wb_ack && wb_adr == end_addr)
            end_seen++;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES)
            @(posedge clock);
        $display("Timeout: the program did not reach its final jump in %0d cycles",
                 TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------
    // Checks and model helpers
    // ----------------------------------------
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic put_byte(input logic [7:0] b);
        wb_mem0.mem[pc] = b;
        pc = pc + 16'd1;
    endtask

    // Stack store with the low byte at SP-2 first
    task automatic expect_push(input logic [15:0] val);
        m_sp = m_sp - 16'd2;
        exp_adr[exp_n]     = m_sp;
        exp_dat[exp_n]     = val[7:0];
        exp_adr[exp_n + 1] = m_sp + 16'd1;
        exp_dat[exp_n + 1] = val[15:8];
        exp_n += 2;
    endtask

    task automatic model_alu(input alu_op_t op, input logic w, input logic [15:0] a,
                             input logic [15:0] b, output logic [15:0] res);
        logic [16:0] full;
        logic [15:0] mask;
        logic [15:0] am;
        logic [15:0] bm;
        int          top;
        logic        sa;
        logic        sb;
        logic        sr;
        mask = w ? 16'hFFFF : 16'h00FF;
        top  = w ? 15 : 7;
        am   = a & mask;
        bm   = b & mask;
        case (op)
            ALU_ADD: full = {1'b0, am} + {1'b0, bm};
            ALU_ADC: full = {1'b0, am} + {1'b0, bm} + {16'd0, m_cf};
            ALU_SBB: full = {1'b0, am} - {1'b0, bm} - {16'd0, m_cf};
            ALU_SUB,
            ALU_CMP: full = {1'b0, am} - {1'b0, bm};
            ALU_AND: full = {1'b0, am & bm};
            ALU_OR:  full = {1'b0, am | bm};
            default: full = {1'b0, am ^ bm};
        endcase
        res  = full[15:0] & mask;
        sa   = am[top];
        sb   = bm[top];
        sr   = res[top];
        m_cf = full[top + 1];   // Borrow shows up here too
        case (op)
            ALU_ADD, ALU_ADC: m_of = (sa == sb) && (sr != sa);
            ALU_SUB, ALU_SBB, ALU_CMP: m_of = (sa != sb) && (sr != sa);
            default: begin
                m_of = 1'b0;
                m_cf = 1'b0;
            end
        endcase
        m_zf = (res == 16'h0000);
        m_sf = sr;
        m_pf = ~^res[7:0];
    endtask

    function automatic logic jump_taken(input logic [7:0] op);
        logic c;
        case (op[3:1])
            3'd0:    c = m_of;
            3'd1:    c = m_cf;
            3'd2:    c = m_zf;
            3'd3:    c = m_cf | m_zf;
            3'd4:    c = m_sf;
            3'd5:    c = m_pf;
            3'd6:    c = m_sf ^ m_of;
            default: c = (m_sf ^ m_of) | m_zf;
        endcase
        return c ^ op[0];
    endfunction

    task automatic fill_table();
        table_rows[0]  = '{ALU_ADD, 1'b1, 16'h7FFF, 16'h0001, 8'h70};
        table_rows[1]  = '{ALU_ADD, 1'b0, 16'h00FF, 16'h0001, 8'h73};
        table_rows[2]  = '{ALU_ADC, 1'b1, 16'h1000, 16'h0001, 8'h74};
        table_rows[3]  = '{ALU_SBB, 1'b0, 16'h0010, 16'h0020, 8'h76};
        table_rows[4]  = '{ALU_OR,  1'b1, 16'h8000, 16'h0001, 8'h78};
        table_rows[5]  = '{ALU_AND, 1'b0, 16'h000F, 16'h0033, 8'h7B};
        table_rows[6]  = '{ALU_SUB, 1'b1, 16'h0005, 16'h0007, 8'h7C};
        table_rows[7]  = '{ALU_XOR, 1'b0, 16'h00AA, 16'h00AA, 8'h7F};
        table_rows[8]  = '{ALU_CMP, 1'b1, 16'h1234, 16'h1234, 8'h75};
        table_rows[9]  = '{ALU_CMP, 1'b0, 16'h0080, 16'h0001, 8'h71};
        table_rows[10] = '{ALU_ADC, 1'b0, 16'h00F0, 16'h0020, 8'h72};
        table_rows[11] = '{ALU_SBB, 1'b1, 16'h0000, 16'h0001, 8'h7E};
        table_rows[12] = '{ALU_ADD, 1'b1, 16'h8000, 16'h8000, 8'h77};
        table_rows[13] = '{ALU_OR,  1'b0, 16'h0000, 16'h0000, 8'h7A};
        table_rows[14] = '{ALU_AND, 1'b1, 16'hFFFF, 16'h8001, 8'h79};
        table_rows[15] = '{ALU_XOR, 1'b1, 16'h1234, 16'h4321, 8'h7D};
        table_rows[16] = '{ALU_SUB, 1'b0, 16'h0080, 16'h0001, 8'h7D};
        table_rows[17] = '{ALU_CMP, 1'b1, 16'h8000, 16'h0001, 8'h7C};
    endtask

    // ----------------------------------------
    // Program and expected stores
    // ----------------------------------------
    task automatic build_program();
        logic [15:0] res;
        // Prologue with MOV DX, STC, INC CX, DEC CX, JC +1, INC DX, XCHG AX,DX and PUSH AX
        put_byte(8'hBA);
        put_byte(8'h34);
        put_byte(8'h12);
        m_dx = 16'h1234;
        put_byte(8'hF9);
        m_cf = 1'b1;
        put_byte(8'h41);
        put_byte(8'h49);
        m_of = 1'b0;            // DEC from 1 to 0
        m_zf = 1'b1;
        put_byte(8'h72);
        put_byte(8'h01);
        put_byte(8'h42);
        if (!m_cf)
            m_dx = m_dx + 16'd1;
        put_byte(8'h92);
        res  = m_ax;
        m_ax = m_dx;
        m_dx = res;
        put_byte(8'h50);
        expect_push(m_ax);

        foreach (table_rows[i]) begin
            put_byte(table_rows[i].w ? 8'hB8 : 8'hB0);   // MOV AX or AL
            put_byte(table_rows[i].a[7:0]);
            if (table_rows[i].w) begin
                put_byte(table_rows[i].a[15:8]);
                m_ax = table_rows[i].a;
            end else begin
                m_ax[7:0] = table_rows[i].a[7:0];
            end
            put_byte({2'b00, table_rows[i].op, 2'b10, table_rows[i].w});
            put_byte(table_rows[i].b[7:0]);
            if (table_rows[i].w)
                put_byte(table_rows[i].b[15:8]);
            model_alu(table_rows[i].op, table_rows[i].w, m_ax, table_rows[i].b, res);
            if (table_rows[i].op != ALU_CMP) begin
                if (table_rows[i].w)
                    m_ax = res;
                else
                    m_ax[7:0] = res[7:0];
            end
            put_byte(8'h50);
            expect_push(m_ax);
            put_byte(table_rows[i].jcc);
            put_byte(8'h01);
            put_byte(8'h41);    // INC CX skipped when taken
            put_byte(8'h51);
            if (!jump_taken(table_rows[i].jcc)) begin
                m_of = (m_cx == 16'h7FFF);
                m_cx = m_cx + 16'd1;
                m_zf = (m_cx == 16'h0000);
                m_sf = m_cx[15];
                m_pf = ~^m_cx[7:0];
            end
            expect_push(m_cx);
        end

        // JO or JNO back to itself as the final OF decides
        end_addr = pc;
        put_byte(m_of ? 8'h70 : 8'h71);
        put_byte(8'hFE);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_n    = 1'b0;
        errors   = 0;
        cycles   = 0;
        end_seen = 0;
        end_addr = 16'hFFFF;
        pc       = RESET_IP;
        exp_n    = 0;
        m_ax     = 16'h0000;
        m_cx     = 16'h0000;
        m_dx     = 16'h0000;
        m_sp     = RESET_SP;
        {m_cf, m_pf, m_zf, m_sf, m_of} = 5'b00000;
        fill_table();

        @(negedge clock);
        build_program();
        repeat (7) @(negedge clock);
        rst_n = 1'b1;

        while (end_seen < 2)
            @(posedge clock);
        @(negedge clock);

        check_value("write count", wb_mem0.log_count, exp_n);
        for (int i = 0; i < exp_n && i < wb_mem0.log_count; i++) begin
            check_value($sformatf("store %0d address", i), wb_mem0.log_adr[i], exp_adr[i]);
            check_value($sformatf("store %0d data", i), wb_mem0.log_dat[i], exp_dat[i]);
        end
        if (wb_mem0.protocol_errors != 0) begin
            errors++;
            $display("The memory model saw Wishbone protocol violations");
        end

        $display("Run complete: %0d errors, %0d bus protocol violations",
                 errors, wb_mem0.protocol_errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* testbench/wb_memory.sv */
`timescale 1ns/1ps

module wb_memory (
    input  logic           clock,
    input  logic           i_cyc,
    input  logic           i_stb,
    input  logic           i_we,
    input  cpu_pkg::word_t i_adr,
    input  cpu_pkg::byte_t i_dat,
    output cpu_pkg::byte_t o_dat,
    output logic           o_ack
);
    logic [7:0]  mem [65536];
    logic [15:0] log_adr [512];     // Every write, in bus order
    logic [7:0]  log_dat [512];
    int          log_count;
    int          protocol_errors;
    logic [31:0] lcg_state;
    int          wait_left;
    logic        pending;           // Cycle seen, ack not yet given
    logic [15:0] pend_adr;
    logic        pend_we;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        for (int i = 0; i < 65536; i++)
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;  // Fill from the whole address
        lcg_state       = 32'd32;
        log_count       = 0;
        protocol_errors = 0;
        pending         = 1'b0;
        wait_left       = 0;
        o_ack           = 1'b0;
        o_dat           = 8'h00;
    end

    // Slave side changes on the falling edge
    always @(negedge clock) begin
        if (i_stb && !i_cyc) begin
            protocol_errors++;
            $display("Bus protocol broken at %0t: stb high without cyc", $time);
        end
        if (o_ack) begin
            o_ack   = 1'b0;     // Master dropped the cycle on that edge
            pending = 1'b0;
        end else if (i_cyc && i_stb) begin
            if (!pending) begin
                lcg_state = lcg_next(lcg_state);
                wait_left = int'(lcg_state[17:16]);   // 0 to 3 cycles
                pending   = 1'b1;
                pend_adr  = i_adr;
                pend_we   = i_we;
            end else if (i_adr !== pend_adr || i_we !== pend_we) begin
                protocol_errors++;
                $display("Bus protocol broken at %0t: address or we moved before ack", $time);
            end
            if (wait_left == 0) begin
                o_ack = 1'b1;
                if (i_we) begin
                    mem[i_adr] = i_dat;
                    if (log_count < 512) begin
                        log_adr[log_count] = i_adr;
                        log_dat[log_count] = i_dat;
                    end
                    log_count++;
                end else begin
                    o_dat = mem[i_adr];
                end
            end else begin
                wait_left--;
            end
        end
    end

endmodule
